// ==== logic/rx_decoder_pkg.sv ====
/*
 shared field lengths and beat types for the ethernet receive decoder,
 imported by the parser, the word packer and the top level
*/

package rx_decoder_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // header field lengths in bytes
   localparam int mac_bytes     = 6;
   localparam int type_bytes    = 2;
   localparam int size_bytes    = 2;
   localparam int counter_bytes = 2;
   // payload bytes packed per output word
   localparam int word_bytes    = 4;

   typedef logic [8*mac_bytes-1:0]     mac_addr_t;
   typedef logic [8*size_bytes-1:0]    pkt_size_t;
   typedef logic [8*counter_bytes-1:0] pkt_counter_t;

   ////////////////////////////////////////////////////////////////////////////
   // input beat, one byte per transfer
   typedef struct packed {
      logic [7:0] data;
      logic       last;
   } rx_byte_t;

   // parser to packer beat
   typedef struct packed {
      logic [7:0]   data;
      logic         last_of_frame;
      pkt_counter_t counter;
   } payload_byte_t;

   // output beat, first payload byte in bits 7:0
   typedef struct packed {
      logic [8*word_bytes-1:0] data;
      logic                    last;
      pkt_counter_t            counter;
   } rx_word_t;

   // header walk, payload pass-through, and swallow of foreign frames
   typedef enum logic [2:0] {
      dest_addr,
      src_addr,
      ether_type,
      size_field,
      counter_field,
      payload,
      discard
   } parse_state_t;

endpackage

// ==== logic/rx_frame_parser.sv ====
/*
 byte level frame parser that filters on destination mac and captures size and
 counter, then passes payload bytes through with zero latency to the word packer
*/

`timescale 1ns/100ps

module rx_frame_parser
   import rx_decoder_pkg::*;
#(
   parameter mac_addr_t station_addr = 48'hda0102030405
) (
   input  logic          axi_tclk,
   input  logic          axi_treset,
   input  logic          enable,
   input  rx_byte_t      rx_byte,
   input  logic          rx_valid,
   output logic          rx_ready,
   output payload_byte_t pay_byte,
   output logic          pay_valid,
   input  logic          pay_ready
);

   // wide enough for the longest header field
   localparam int cnt_w = $clog2(mac_bytes);

   parse_state_t     state;
   logic [cnt_w-1:0] field_cnt;
   logic             field_end;
   logic             armed;
   logic             take;
   // up to five address bytes taken so far
   logic [8*(mac_bytes-1)-1:0] dest_shift;
   mac_addr_t        addr_next;
   logic             addr_match;
   pkt_size_t        pkt_size;
   pkt_counter_t     pkt_counter;
   pkt_size_t        remaining;
   logic             final_byte;

   ////////////////////////////////////////////////////////////////////////////
   // input handshake

   // low for one cycle after reset and high from then on
   always_ff @(posedge axi_tclk) begin
      if (axi_treset) begin
         armed <= 1'b0;
      end else begin
         armed <= 1'b1;
      end
   end

   always_comb begin
      case (state)
         // enable only gates the start of a new frame
         dest_addr: rx_ready = armed & (enable | (field_cnt != '0));
         src_addr, ether_type, size_field, counter_field: rx_ready = 1'b1;
         // keep swallowing to the end of a foreign frame
         discard: rx_ready = 1'b1;
         // payload stalls with the packer
         payload: rx_ready = pay_ready;
         default: rx_ready = 1'b0;
      endcase
   end

   assign take = rx_valid & rx_ready;

   ////////////////////////////////////////////////////////////////////////////
   // field byte counting

   // end of the current header field
   always_comb begin
      case (state)
         dest_addr, src_addr: field_end = (field_cnt == cnt_w'(mac_bytes - 1));
         ether_type:          field_end = (field_cnt == cnt_w'(type_bytes - 1));
         size_field:          field_end = (field_cnt == cnt_w'(size_bytes - 1));
         counter_field:       field_end = (field_cnt == cnt_w'(counter_bytes - 1));
         default:             field_end = 1'b0;
      endcase
   end

   // address with the bus byte shifted in msb first
   assign addr_next  = {dest_shift, rx_byte.data};
   assign addr_match = (addr_next == station_addr);

   // last payload byte of the frame
   assign final_byte = (remaining == pkt_size_t'(1));

   ////////////////////////////////////////////////////////////////////////////
   // state machine

   always_ff @(posedge axi_tclk) begin
      if (axi_treset) begin
         state     <= dest_addr;
         field_cnt <= '0;
         remaining <= '0;
      end else if (take) begin
         case (state)
            dest_addr: begin
               if (field_end) begin
                  field_cnt <= '0;
                  // decision on the sixth address byte
                  state     <= addr_match ? src_addr : discard;
               end else begin
                  field_cnt <= field_cnt + 1'b1;
               end
            end
            src_addr: begin
               if (field_end) begin
                  field_cnt <= '0;
                  state     <= ether_type;
               end else begin
                  field_cnt <= field_cnt + 1'b1;
               end
            end
            ether_type: begin
               if (field_end) begin
                  field_cnt <= '0;
                  state     <= size_field;
               end else begin
                  field_cnt <= field_cnt + 1'b1;
               end
            end
            size_field: begin
               if (field_end) begin
                  field_cnt <= '0;
                  state     <= counter_field;
               end else begin
                  field_cnt <= field_cnt + 1'b1;
               end
            end
            counter_field: begin
               if (field_end) begin
                  field_cnt <= '0;
                  // size covers the counter bytes as well
                  remaining <= pkt_size - pkt_size_t'(counter_bytes);
                  state     <= payload;
               end else begin
                  field_cnt <= field_cnt + 1'b1;
               end
            end
            payload: begin
               remaining <= remaining - 1'b1;
               if (final_byte) begin
                  state <= dest_addr;
               end
            end
            discard: begin
               if (rx_byte.last) begin
                  state <= dest_addr;
               end
            end
            default: begin
               state     <= dest_addr;
               field_cnt <= '0;
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // header field capture

   always_ff @(posedge axi_tclk) begin
      if (take) begin
         if (state == dest_addr) begin
            dest_shift <= addr_next[8*(mac_bytes-1)-1:0];
         end
         // size is big endian
         if (state == size_field) begin
            pkt_size <= {pkt_size[7:0], rx_byte.data};
         end
         // counter is little endian so each byte shifts in from the top
         if (state == counter_field) begin
            pkt_counter <= {rx_byte.data, pkt_counter[8*counter_bytes-1:8]};
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // payload stream to the packer

   assign pay_valid              = rx_valid & (state == payload);
   assign pay_byte.data          = rx_byte.data;
   assign pay_byte.last_of_frame = final_byte;
   assign pay_byte.counter       = pkt_counter;

endmodule

// ==== logic/rx_word_packer.sv ====
/*
 packs payload bytes into 32 bit words, first byte in the low lane,
 with a one deep output register that holds against back-pressure
*/

`timescale 1ns/100ps

module rx_word_packer
   import rx_decoder_pkg::*;
(
   input  logic          axi_tclk,
   input  logic          axi_treset,
   input  payload_byte_t pay_byte,
   input  logic          pay_valid,
   output logic          pay_ready,
   output rx_word_t      out_word,
   output logic          out_valid,
   input  logic          out_ready
);

   localparam int lane_w = $clog2(word_bytes);

   logic [lane_w-1:0]             lane;
   logic                          lane_full;
   // lower lanes only, the top byte goes straight to the output
   logic [8*(word_bytes-1)-1:0]   asm_data;
   pkt_counter_t                  asm_counter;
   logic                          out_free;
   logic                          take;

   ////////////////////////////////////////////////////////////////////////////
   // byte side handshake

   assign lane_full = (lane == lane_w'(word_bytes - 1));
   // output register empty or emptying this cycle
   assign out_free  = ~out_valid | out_ready;
   // only the closing byte waits on the output register
   assign pay_ready = ~lane_full | out_free;
   assign take      = pay_valid & pay_ready;

   // lane pointer, wraps after each word
   always_ff @(posedge axi_tclk) begin
      if (axi_treset) begin
         lane <= '0;
      end else if (take) begin
         lane <= lane + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // assembly register

   always_ff @(posedge axi_tclk) begin
      if (take && !lane_full) begin
         asm_data[8*lane +: 8] <= pay_byte.data;
      end
      // counter taken from the first byte of each word
      if (take && lane == '0) begin
         asm_counter <= pay_byte.counter;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // output hold stage

   always_ff @(posedge axi_tclk) begin
      if (axi_treset) begin
         out_valid <= 1'b0;
      end else if (take && lane_full) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   // word completes on the fourth byte
   always_ff @(posedge axi_tclk) begin
      if (take && lane_full) begin
         out_word.data    <= {pay_byte.data, asm_data};
         // frame end comes from the parser only
         out_word.last    <= pay_byte.last_of_frame;
         out_word.counter <= asm_counter;
      end
   end

endmodule

// ==== logic/rx_decoder_top.sv ====
/*
 receive decoder top level, joins the frame parser and the word packer
 and sets the station address that frames are filtered on
*/

`timescale 1ns/100ps

module rx_decoder_top
   import rx_decoder_pkg::*;
#(
   // frames for any other destination are dropped
   parameter mac_addr_t station_addr = 48'hda0102030405
) (
   input  logic     axi_tclk,
   input  logic     axi_treset,
   input  logic     enable,
   // byte stream in
   input  rx_byte_t rx_byte,
   input  logic     rx_valid,
   output logic     rx_ready,
   // word stream out
   output rx_word_t out_word,
   output logic     out_valid,
   input  logic     out_ready
);

   ////////////////////////////////////////////////////////////////////////////
   // parser to packer link
   payload_byte_t pay_byte;
   logic          pay_valid;
   logic          pay_ready;

   // header walk and address filter
   rx_frame_parser #(
      .station_addr (station_addr)
   ) u_parser (
      .axi_tclk   (axi_tclk),
      .axi_treset (axi_treset),
      .enable     (enable),
      .rx_byte    (rx_byte),
      .rx_valid   (rx_valid),
      .rx_ready   (rx_ready),
      .pay_byte   (pay_byte),
      .pay_valid  (pay_valid),
      .pay_ready  (pay_ready)
   );

   // byte to word repack
   rx_word_packer u_packer (
      .axi_tclk   (axi_tclk),
      .axi_treset (axi_treset),
      .pay_byte   (pay_byte),
      .pay_valid  (pay_valid),
      .pay_ready  (pay_ready),
      .out_word   (out_word),
      .out_valid  (out_valid),
      .out_ready  (out_ready)
   );

endmodule

// ==== testbench/rx_decoder_assertions.sv ====
/*
 concurrent checks on the decoder output handshake, reset release and parser
 state, bound into the top level
*/

`timescale 1ns/100ps

module rx_decoder_assertions
   import rx_decoder_pkg::*;
(
   input logic         axi_tclk,
   input logic         axi_treset,
   input logic         rx_ready,
   input logic         out_valid,
   input logic         out_ready,
   input rx_word_t     out_word,
   input parse_state_t state
);

   // a stalled word stays offered and unchanged
   output_holds: assert property (
      @(posedge axi_tclk) disable iff (axi_treset)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_word))
   ) else $error("out_word changed or dropped while out_ready was low");

   // nothing offered on the first cycle out of reset
   quiet_after_reset: assert property (
      @(posedge axi_tclk) $fell(axi_treset) |-> (!rx_ready && !out_valid)
   ) else $error("rx_ready or out_valid high on the first cycle after reset");

   state_legal: assert property (
      @(posedge axi_tclk) disable iff (axi_treset)
      state inside {dest_addr, src_addr, ether_type, size_field, counter_field,
                    payload, discard}
   ) else $error("parser state outside its enumeration");

endmodule

bind rx_decoder_top rx_decoder_assertions u_assertions (
   .axi_tclk   (axi_tclk),
   .axi_treset (axi_treset),
   .rx_ready   (rx_ready),
   .out_valid  (out_valid),
   .out_ready  (out_ready),
   .out_word   (out_word),
   .state      (u_parser.state)
);

// ==== testbench/rx_decoder_tb.sv ====
/*
 testbench for the receive decoder, random frames from a fixed seed with some
 for a foreign station, checked word by word against a queue of expected words
*/

`timescale 1ns/100ps

module rx_decoder_tb
   import rx_decoder_pkg::*;
();

   localparam mac_addr_t station    = 48'h5a0102030405;
   localparam int num_frames        = 40;
   localparam int max_frame_bytes   = 82;
   localparam int timeout_cycles    = num_frames * max_frame_bytes * 8;
   // cycles that enable is held low in front of a frame
   localparam int hold_cycles       = 6;

   logic        axi_tclk;
   logic        axi_treset;
   logic        enable;
   rx_byte_t    rx_byte;
   logic        rx_valid;
   logic        rx_ready;
   rx_word_t    out_word;
   logic        out_valid;
   logic        out_ready;

   rx_byte_t    frame_q[$];
   rx_word_t    expected_q[$];
   logic [31:0] gen_state;
   logic [31:0] stall_state;
   int          errors = 0;
   int          words_checked = 0;
   int          cycle_count;

   rx_decoder_top #(
      .station_addr (station)
   ) uut (
      .axi_tclk   (axi_tclk),
      .axi_treset (axi_treset),
      .enable     (enable),
      .rx_byte    (rx_byte),
      .rx_valid   (rx_valid),
      .rx_ready   (rx_ready),
      .out_word   (out_word),
      .out_valid  (out_valid),
      .out_ready  (out_ready)
   );

   initial begin
      axi_tclk = 1'b0;
      forever #2 axi_tclk = ~axi_tclk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [31:0] next_gen();
      gen_state = xorshift32(gen_state);
      return gen_state;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // frame generator and reference model

   // fills frame_q, and expected_q too when the frame is for this station
   task automatic build_frame();
      logic [31:0]  r;
      logic [31:0]  lo;
      logic         foreign;
      mac_addr_t    dest;
      pkt_size_t    size;
      pkt_counter_t counter;
      int           len;
      logic [7:0]   pay [64];
      rx_word_t     w;
      frame_q.delete();
      r       = next_gen();
      lo      = next_gen();
      foreign = (r[1:0] == 2'b00);
      len     = 4 * (int'(r[7:4]) + 1);
      size    = pkt_size_t'(len + counter_bytes);
      counter = r[31:16];
      // bit 8 always flips, so a foreign address never equals the station
      dest    = foreign ? (station ^ {r[15:8], lo | 32'd1, 8'h00}) : station;
      for (int i = mac_bytes - 1; i >= 0; i--) begin
         frame_q.push_back(rx_byte_t'{data: dest[8*i +: 8], last: 1'b0});
      end
      // source address and ethertype, random filler
      for (int i = 0; i < mac_bytes + type_bytes; i++) begin
         r = next_gen();
         frame_q.push_back(rx_byte_t'{data: r[7:0], last: 1'b0});
      end
      // size big endian, counter little endian
      frame_q.push_back(rx_byte_t'{data: size[15:8], last: 1'b0});
      frame_q.push_back(rx_byte_t'{data: size[7:0], last: 1'b0});
      frame_q.push_back(rx_byte_t'{data: counter[7:0], last: 1'b0});
      frame_q.push_back(rx_byte_t'{data: counter[15:8], last: 1'b0});
      for (int i = 0; i < len; i++) begin
         r      = next_gen();
         pay[i] = r[7:0];
         frame_q.push_back(rx_byte_t'{data: pay[i], last: (i == len - 1)});
      end
      if (!foreign) begin
         for (int i = 0; i < len; i += word_bytes) begin
            w.data    = {pay[i+3], pay[i+2], pay[i+1], pay[i]};
            w.last    = (i + word_bytes == len);
            w.counter = counter;
            expected_q.push_back(w);
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // input driver, random gaps, optional enable hold at the frame start

   task automatic send_frame(input logic hold);
      int          idx;
      int          waited;
      logic        pending;
      logic [31:0] r;
      idx     = 0;
      waited  = 0;
      pending = 1'b0;
      while (idx < frame_q.size()) begin
         @(negedge axi_tclk);
         enable = !(hold && waited < hold_cycles);
         // a beat already offered stays until it is taken
         if (!pending) begin
            r = next_gen();
            if (r[1:0] == 2'b00 && enable) begin
               rx_valid = 1'b0;
            end else begin
               rx_byte  = frame_q[idx];
               rx_valid = 1'b1;
               pending  = 1'b1;
            end
         end
         #1;
         if (!enable) begin
            check_value("rx_ready", 32'(rx_ready), 32'd0);
            waited++;
         end
         if (pending && rx_ready) begin
            idx++;
            pending = 1'b0;
         end
      end
   endtask

   task automatic compare_word();
      rx_word_t exp;
      if (expected_q.size() == 0) begin
         $display("output word %h at %0t arrived with no word expected", out_word.data, $time);
         errors++;
      end else begin
         exp = expected_q.pop_front();
         check_value("out_word.data", out_word.data, exp.data);
         check_value("out_word.last", 32'(out_word.last), 32'(exp.last));
         check_value("out_word.counter", 32'(out_word.counter), 32'(exp.counter));
         words_checked++;
      end
   endtask

   // output side, random stalls, words taken when valid and ready
   initial begin
      stall_state = 32'd43;
      out_ready   = 1'b0;
      forever begin
         @(negedge axi_tclk);
         stall_state = xorshift32(stall_state);
         out_ready   = (stall_state[2:1] != 2'b00);
         #1;
         if (out_valid && out_ready) begin
            compare_word();
         end
      end
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < timeout_cycles) begin
         @(posedge axi_tclk);
         cycle_count++;
      end
      $display("timeout after %0d cycles, %0d words never arrived", cycle_count,
               expected_q.size());
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      axi_treset = 1'b1;
      enable     = 1'b1;
      rx_byte    = '0;
      rx_valid   = 1'b0;
      gen_state  = 32'd43;
      repeat (5) @(posedge axi_tclk);
      @(negedge axi_tclk);
      axi_treset = 1'b0;
      #1;
      // first cycle out of reset
      check_value("rx_ready", 32'(rx_ready), 32'd0);
      check_value("out_valid", 32'(out_valid), 32'd0);
      for (int f = 0; f < num_frames; f++) begin
         build_frame();
         send_frame(f % 8 == 5);
      end
      @(negedge axi_tclk);
      rx_valid = 1'b0;
      while (expected_q.size() != 0) begin
         @(negedge axi_tclk);
      end
      // quiet tail, so extra words still show up
      repeat (50) @(negedge axi_tclk);
      $display("frames %0d, words checked %0d, errors %0d", num_frames, words_checked, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== project.f ====
logic/rx_decoder_pkg.sv
logic/rx_frame_parser.sv
logic/rx_word_packer.sv
logic/rx_decoder_top.sv
testbench/rx_decoder_assertions.sv
testbench/rx_decoder_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the receive decoder testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert --timing -Wno-fatal --top-module rx_decoder_tb \
   -f project.f --Mdir "$build_dir" -o rx_decoder_sim
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

"./$build_dir/rx_decoder_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi
if grep -q "SOME TESTS FAILED" "$log_file"; then
   exit 1
fi
exit 0
